// ==== src/tscPkg.sv ====
package tscPkg;

	typedef logic [15:0] word_t;
	typedef logic [1:0] regIdx_t;

	// Instruction class in bits 15..12
	typedef enum logic [3:0] {
		opAdi = 4'd4,
		opOri = 4'd5,
		opLhi = 4'd6,
		opLwd = 4'd7,
		opSwd = 4'd8,
		opAlu = 4'd15
	} opcode_t;

	// R-type function in bits 5..0
	typedef enum logic [5:0] {
		fnAdd = 6'd0,
		fnSub = 6'd1,
		fnAnd = 6'd2,
		fnOrr = 6'd3,
		fnNot = 6'd4,
		fnTcp = 6'd5,
		fnShl = 6'd6,
		fnShr = 6'd7,
		fnWwd = 6'd28,
		fnHlt = 6'd29
	} funcCode_t;

	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluNot,
		aluTcp,
		aluShl,
		aluShr,
		aluPassA,
		aluPassB
	} aluOp_t;

	typedef enum logic [1:0] {
		fwdReg,
		fwdMem,
		fwdWb
	} fwdSel_t;

	// Everything later stages need, decided once in decode
	typedef struct packed {
		aluOp_t aluOp;
		logic   aluSrcImm;
		logic   memRead;
		logic   memWrite;
		logic   regWrite;
		logic   memToReg;
		logic   isWwd;
		logic   isHalt;
		logic   usesRs1;
		logic   usesRs2;
	} ctrl_t;

	typedef struct packed {
		logic    valid;
		ctrl_t   ctrl;
		regIdx_t rs1;
		regIdx_t rs2;
		regIdx_t rd;
		word_t   imm;
		word_t   readData1;
		word_t   readData2;
	} idExReg_t;

	typedef struct packed {
		logic    valid;
		ctrl_t   ctrl;
		regIdx_t rd;
		word_t   aluResult;
		word_t   storeData;
		word_t   operandA;
	} exMemReg_t;

	typedef struct packed {
		logic    valid;
		ctrl_t   ctrl;
		regIdx_t rd;
		word_t   aluResult;
		word_t   loadData;
		word_t   operandA;
	} memWbReg_t;

endpackage

// ==== src/alu.sv ====
`timescale 1ns/1ps

module alu (
	input  tscPkg::word_t  a,
	input  tscPkg::word_t  b,
	input  tscPkg::aluOp_t op,
	output tscPkg::word_t  result
);
	import tscPkg::*;

	always_comb begin
		case (op)
			aluAdd:
				result = a + b;
			aluSub:
				result = a - b;
			aluAnd:
				result = a & b;
			aluOr:
				result = a | b;
			aluNot:
				result = ~a;
			aluTcp:
				result = ~a + 16'd1;
			aluShl:
				result = {a[14:0], 1'b0};
			// Arithmetic, sign bit stays
			aluShr:
				result = {a[15], a[15:1]};
			aluPassB:
				result = b;
			default:
				result = a;
		endcase
	end

	// Once the operands are settled out of reset the operation must be too
	always_comb begin
		if (!$isunknown({a, b})) begin
			opKnown: assert final (!$isunknown(op))
				else $error("alu: operation unknown with defined operands");
		end
	end

endmodule

// ==== src/regFile.sv ====
`timescale 1ns/1ps

module regFile (
	input  logic            clk,
	input  logic            reset_n,
	input  tscPkg::regIdx_t rs1,
	input  tscPkg::regIdx_t rs2,
	input  tscPkg::regIdx_t rd,
	input  tscPkg::word_t   writeData,
	input  logic            regWrite,
	output tscPkg::word_t   readData1,
	output tscPkg::word_t   readData2
);
	import tscPkg::*;

	word_t regs [4];

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			regs <= '{default: '0};
		end else if (regWrite) begin
			regs[rd] <= writeData;
		end
	end

	// Write-through so decode sees the value retiring this cycle
	assign readData1 = (regWrite && rd == rs1) ? writeData : regs[rs1];
	assign readData2 = (regWrite && rd == rs2) ? writeData : regs[rs2];

endmodule

// ==== src/instDecoder.sv ====
`timescale 1ns/1ps

module instDecoder (
	input  tscPkg::word_t   instruction,
	output tscPkg::regIdx_t rs1,
	output tscPkg::regIdx_t rs2,
	output tscPkg::regIdx_t rd,
	output tscPkg::word_t   imm,
	output tscPkg::ctrl_t   ctrl
);
	import tscPkg::*;

	opcode_t    opcode;
	funcCode_t  funcCode;
	logic [7:0] immField;

	assign opcode = opcode_t'(instruction[15:12]);
	assign funcCode = funcCode_t'(instruction[5:0]);
	assign immField = instruction[7:0];
	assign rs1 = instruction[11:10];
	assign rs2 = instruction[9:8];

	always_comb begin
		ctrl = '0;
		ctrl.aluOp = aluPassA;
		rd = instruction[9:8];
		imm = {{8{immField[7]}}, immField};
		case (opcode)
			opAdi: begin
				ctrl.aluOp = aluAdd;
				ctrl.aluSrcImm = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.usesRs1 = 1'b1;
			end
			opOri: begin
				imm = {8'h00, immField};
				ctrl.aluOp = aluOr;
				ctrl.aluSrcImm = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.usesRs1 = 1'b1;
			end
			opLhi: begin
				imm = {immField, 8'h00};
				ctrl.aluOp = aluPassB;
				ctrl.aluSrcImm = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			opLwd: begin
				ctrl.aluOp = aluAdd;
				ctrl.aluSrcImm = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.usesRs1 = 1'b1;
			end
			// Bits 9..8 name the register to store
			opSwd: begin
				ctrl.aluOp = aluAdd;
				ctrl.aluSrcImm = 1'b1;
				ctrl.memWrite = 1'b1;
				ctrl.usesRs1 = 1'b1;
				ctrl.usesRs2 = 1'b1;
			end
			opAlu: begin
				rd = instruction[7:6];
				ctrl.usesRs1 = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.usesRs2 = funcCode inside {fnAdd, fnSub, fnAnd, fnOrr};
				case (funcCode)
					fnAdd:
						ctrl.aluOp = aluAdd;
					fnSub:
						ctrl.aluOp = aluSub;
					fnAnd:
						ctrl.aluOp = aluAnd;
					fnOrr:
						ctrl.aluOp = aluOr;
					fnNot:
						ctrl.aluOp = aluNot;
					fnTcp:
						ctrl.aluOp = aluTcp;
					fnShl:
						ctrl.aluOp = aluShl;
					fnShr:
						ctrl.aluOp = aluShr;
					fnWwd: begin
						ctrl.regWrite = 1'b0;
						ctrl.isWwd = 1'b1;
					end
					fnHlt: begin
						ctrl.regWrite = 1'b0;
						ctrl.usesRs1 = 1'b0;
						ctrl.isHalt = 1'b1;
					end
					default: begin
						ctrl.regWrite = 1'b0;
						ctrl.usesRs1 = 1'b0;
					end
				endcase
			end
			default: begin
				// Unknown class retires as a no-op
			end
		endcase
	end

endmodule

// ==== src/hazardUnit.sv ====
`timescale 1ns/1ps

module hazardUnit (
	input  logic              clk,
	input  logic              reset_n,
	input  tscPkg::regIdx_t   decRs1,
	input  tscPkg::regIdx_t   decRs2,
	input  tscPkg::ctrl_t     decCtrl,
	input  tscPkg::idExReg_t  idEx,
	input  tscPkg::exMemReg_t exMem,
	input  tscPkg::memWbReg_t memWb,
	output logic              stall,
	output tscPkg::fwdSel_t   fwdA,
	output tscPkg::fwdSel_t   fwdB
);
	import tscPkg::*;

	// Memory stage wins over writeback; a load in memory has no data yet
	function automatic fwdSel_t pickSource(regIdx_t src, logic used);
		fwdSel_t sel;
		sel = fwdReg;
		if (used && memWb.valid && memWb.ctrl.regWrite && memWb.rd == src)
			sel = fwdWb;
		if (used && exMem.valid && exMem.ctrl.regWrite && !exMem.ctrl.memRead
				&& exMem.rd == src)
			sel = fwdMem;
		return sel;
	endfunction

	always_comb begin
		fwdA = pickSource(idEx.rs1, idEx.ctrl.usesRs1);
		fwdB = pickSource(idEx.rs2, idEx.ctrl.usesRs2);
	end

	// Load in execute feeding the instruction in decode
	assign stall = idEx.valid && idEx.ctrl.memRead
		&& ((decCtrl.usesRs1 && decRs1 == idEx.rd) || (decCtrl.usesRs2 && decRs2 == idEx.rd));

	// The bubble inserted on a stall must clear the hazard by itself
	singleStall: assert property (@(posedge clk) disable iff (!reset_n) stall |=> !stall)
		else $error("hazardUnit: stall held for two cycles");

endmodule

// ==== src/pipelineCpu.sv ====
`timescale 1ns/1ps

module pipelineCpu (
	input  logic          clk,
	input  logic          reset_n,
	output tscPkg::word_t instAddr,
	input  tscPkg::word_t instData,
	output tscPkg::word_t dataAddr,
	output logic          dataRead,
	output logic          dataWrite,
	output tscPkg::word_t dataWriteData,
	input  tscPkg::word_t dataReadData,
	output tscPkg::word_t numInst,
	output tscPkg::word_t outputPort,
	output logic          halted
);
	import tscPkg::*;

	word_t     pc;
	word_t     ifIdInst;
	logic      ifIdValid;
	idExReg_t  idEx;
	exMemReg_t exMem;
	memWbReg_t memWb;
	logic      haltFlag;

	regIdx_t decRs1;
	regIdx_t decRs2;
	regIdx_t decRd;
	word_t   decImm;
	ctrl_t   decCtrl;
	ctrl_t   decCtrlLive;
	word_t   readData1;
	word_t   readData2;

	logic    stall;
	fwdSel_t fwdA;
	fwdSel_t fwdB;
	word_t   opA;
	word_t   opB;
	word_t   aluResult;
	word_t   wbData;
	logic    retire;

	function automatic word_t fwdMux(fwdSel_t sel, word_t regVal);
		case (sel)
			fwdMem:
				return exMem.aluResult;
			fwdWb:
				return wbData;
			default:
				return regVal;
		endcase
	endfunction

	assign halted = haltFlag || (memWb.valid && memWb.ctrl.isHalt);
	assign retire = memWb.valid && !haltFlag;
	assign wbData = memWb.ctrl.memToReg ? memWb.loadData : memWb.aluResult;

	// Empty or frozen decode slot carries no control
	assign decCtrlLive = (ifIdValid && !halted) ? decCtrl : '0;

	assign instAddr = pc;
	assign dataAddr = exMem.aluResult;
	assign dataWriteData = exMem.storeData;
	assign dataRead = exMem.valid && exMem.ctrl.memRead && !halted;
	assign dataWrite = exMem.valid && exMem.ctrl.memWrite && !halted;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			pc <= '0;
			ifIdValid <= 1'b0;
		end else if (!halted && !stall) begin
			pc <= pc + 16'd1;
			ifIdValid <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!halted && !stall)
			ifIdInst <= instData;
	end

	instDecoder i_decoder (
		.instruction (ifIdInst),
		.rs1         (decRs1),
		.rs2         (decRs2),
		.rd          (decRd),
		.imm         (decImm),
		.ctrl        (decCtrl)
	);

	regFile i_regFile (
		.clk       (clk),
		.reset_n   (reset_n),
		.rs1       (decRs1),
		.rs2       (decRs2),
		.rd        (memWb.rd),
		.writeData (wbData),
		.regWrite  (retire && memWb.ctrl.regWrite),
		.readData1 (readData1),
		.readData2 (readData2)
	);

	hazardUnit i_hazard (
		.clk     (clk),
		.reset_n (reset_n),
		.decRs1  (decRs1),
		.decRs2  (decRs2),
		.decCtrl (decCtrlLive),
		.idEx    (idEx),
		.exMem   (exMem),
		.memWb   (memWb),
		.stall   (stall),
		.fwdA    (fwdA),
		.fwdB    (fwdB)
	);

	always_ff @(posedge clk) begin
		if (!reset_n || (stall && !halted)) begin
			idEx <= '0;
		end else if (!halted) begin
			idEx <= '{valid: ifIdValid, ctrl: decCtrlLive, rs1: decRs1, rs2: decRs2,
				rd: decRd, imm: decImm, readData1: readData1, readData2: readData2};
		end
	end

	assign opA = fwdMux(fwdA, idEx.readData1);
	assign opB = fwdMux(fwdB, idEx.readData2);

	alu i_alu (
		.a      (opA),
		.b      (idEx.ctrl.aluSrcImm ? idEx.imm : opB),
		.op     (idEx.ctrl.aluOp),
		.result (aluResult)
	);

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			exMem <= '0;
			memWb <= '0;
		end else if (!halted) begin
			exMem <= '{valid: idEx.valid, ctrl: idEx.ctrl, rd: idEx.rd,
				aluResult: aluResult, storeData: opB, operandA: opA};
			memWb <= '{valid: exMem.valid, ctrl: exMem.ctrl, rd: exMem.rd,
				aluResult: exMem.aluResult, loadData: dataReadData, operandA: exMem.operandA};
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			numInst <= '0;
			outputPort <= '0;
			haltFlag <= 1'b0;
		end else if (retire) begin
			numInst <= numInst + 16'd1;
			if (memWb.ctrl.isWwd)
				outputPort <= memWb.operandA;
			if (memWb.ctrl.isHalt)
				haltFlag <= 1'b1;
		end
	end

	// Decode never sets both, and the pipeline must keep it that way
	memExclusive: assert property (@(posedge clk) disable iff (!reset_n)
		!(dataRead && dataWrite))
		else $error("pipelineCpu: data read and write in the same cycle");

endmodule

// ==== bench/programTable.svh ====
`ifndef PROGRAM_TABLE_SVH
`define PROGRAM_TABLE_SVH

localparam int NumTests = 5;
localparam int MaxWords = 16;
localparam int MaxOuts = 8;
localparam int MaxWrites = 2;

string testName [NumTests] = '{"rtype forwarding", "immediates", "unary and shifts",
	"store load stall", "halt freeze"};

int progLength [NumTests] = '{11, 11, 11, 11, 8};

// Words past progLength are padding and never loaded
word_t progWords [NumTests][MaxWords] = '{
	'{16'h4136, 16'h421B, 16'hF6C0, 16'hFB01, 16'hF342, 16'hF683, 16'hF81C, 16'hF41C,
		16'hF01C, 16'hFC1C, 16'hF01D, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
	'{16'h4185, 16'hF41C, 16'h529C, 16'hF81C, 16'h63A7, 16'hFC1C, 16'h5F42, 16'hFC1C,
		16'h4FFE, 16'hFC1C, 16'hF01D, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
	'{16'h6196, 16'h550B, 16'hF484, 16'hF81C, 16'hF485, 16'hF81C, 16'hF4C6, 16'hFC1C,
		16'hF4C7, 16'hFC1C, 16'hF01D, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
	'{16'h4120, 16'h625A, 16'h5AC3, 16'h8603, 16'h7703, 16'hFD00, 16'hF01C, 16'h7620,
		16'hF81C, 16'h86FF, 16'hF01D, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
	'{16'h4111, 16'hF41C, 16'h4222, 16'hF01D, 16'h8210, 16'hF81C, 16'h4501, 16'hF41C,
		16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000}
};

word_t preloadAddr [NumTests] = '{16'h0080, 16'h0081, 16'h0082, 16'h0040, 16'h0010};
word_t preloadData [NumTests] = '{16'h1111, 16'h2222, 16'h3333, 16'h7E31, 16'h0D0D};

int outCount [NumTests] = '{4, 5, 4, 2, 1};
word_t expOut [NumTests][MaxOuts] = '{
	'{16'h005B, 16'h0040, 16'hFFCA, 16'h0051, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
	'{16'hFF85, 16'h009C, 16'hA700, 16'hA742, 16'hA740, 16'h0000, 16'h0000, 16'h0000},
	'{16'h69F4, 16'h69F5, 16'h2C16, 16'hCB05, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
	'{16'h5AE3, 16'h7E31, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
	'{16'h0011, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000}
};

word_t expNumInst [NumTests] = '{16'd11, 16'd11, 16'd11, 16'd11, 16'd4};

int writeCount [NumTests] = '{0, 0, 0, 2, 0};
word_t expWrAddr [NumTests][MaxWrites] = '{'{16'h0, 16'h0}, '{16'h0, 16'h0},
	'{16'h0, 16'h0}, '{16'h0023, 16'h001F}, '{16'h0, 16'h0}};
word_t expWrData [NumTests][MaxWrites] = '{'{16'h0, 16'h0}, '{16'h0, 16'h0},
	'{16'h0, 16'h0}, '{16'h5AC3, 16'h7E31}, '{16'h0, 16'h0}};

`endif

// ==== bench/pipelineCpuTb.sv ====
`timescale 1ns/1ps

module pipelineCpuTb;
	import tscPkg::*;

	`include "programTable.svh"

	logic  clk;
	logic  reset_n;
	word_t instAddr;
	word_t instData;
	word_t dataAddr;
	logic  dataRead;
	logic  dataWrite;
	word_t dataWriteData;
	word_t dataReadData;
	word_t numInst;
	word_t outputPort;
	logic  halted;

	word_t instMem [256];
	word_t dataMem [256];
	word_t outLog [$];
	word_t wrAddrLog [$];
	word_t wrDataLog [$];
	int    testErrors;
	int    cycleCount;
	int    cycleLimit;
	string currentTest;

	pipelineCpu i_dut (
		.clk           (clk),
		.reset_n       (reset_n),
		.instAddr      (instAddr),
		.instData      (instData),
		.dataAddr      (dataAddr),
		.dataRead      (dataRead),
		.dataWrite     (dataWrite),
		.dataWriteData (dataWriteData),
		.dataReadData  (dataReadData),
		.numInst       (numInst),
		.outputPort    (outputPort),
		.halted        (halted)
	);

	// Both memories answer in the same cycle, data only on a read
	assign instData = instMem[instAddr[7:0]];
	assign dataReadData = dataRead ? dataMem[dataAddr[7:0]] : 'x;

	always @(posedge clk) begin
		if (dataWrite)
			dataMem[dataAddr[7:0]] <= dataWriteData;
	end

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic checkWord(input word_t got, input word_t exp, input string what);
		if (got !== exp) begin
			$display("FAILED at %0t ns: %s got %h, expected %h", $time, what, got, exp);
			testErrors++;
		end
	endtask

	task automatic checkFlag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("FAILED at %0t ns: %s got %b, expected %b", $time, what, got, exp);
			testErrors++;
		end
	endtask

	task automatic checkCount(input word_t got, input word_t exp, input string what);
		if (got !== exp) begin
			$display("FAILED at %0t ns: %s got %0d, expected %0d", $time, what, got, exp);
			testErrors++;
		end
	endtask

	// Unused instruction words decode as no-ops
	task automatic loadProgram(input int t);
		int i;
		for (i = 0; i < 256; i++) begin
			instMem[i] = {8'h00, i[7:0]};
			dataMem[i] = {~i[7:0], i[7:0]};
		end
		for (i = 0; i < progLength[t]; i++)
			instMem[i] = progWords[t][i];
		dataMem[preloadAddr[t][7:0]] = preloadData[t];
	endtask

	task automatic applyReset(input int t);
		reset_n = 1'b0;
		loadProgram(t);
		repeat (3) @(posedge clk);
		#1 reset_n = 1'b1;
	endtask

	// Runs until halted, then watches a few more cycles for leaks
	task automatic runProgram();
		int    afterHalt;
		logic  haltSeen;
		word_t lastOut;
		outLog.delete();
		wrAddrLog.delete();
		wrDataLog.delete();
		afterHalt = 0;
		haltSeen = 1'b0;
		lastOut = outputPort;
		while (afterHalt < 4) begin
			@(posedge clk);
			#1;
			if (dataWrite) begin
				if (halted) begin
					$display("Data write to %h while halted at %0t ns", dataAddr, $time);
					testErrors++;
				end
				wrAddrLog.push_back(dataAddr);
				wrDataLog.push_back(dataWriteData);
			end
			if (outputPort !== lastOut) begin
				outLog.push_back(outputPort);
				lastOut = outputPort;
			end
			if (haltSeen) begin
				checkFlag(halted, 1'b1, "halted held");
				afterHalt++;
			end else if (halted) begin
				haltSeen = 1'b1;
			end
		end
	endtask

	task automatic compareResults(input int t);
		int i;
		checkCount(numInst, expNumInst[t], "retired count");
		checkCount(word_t'(outLog.size()), word_t'(outCount[t]), "outputPort updates");
		for (i = 0; i < outLog.size() && i < outCount[t]; i++)
			checkWord(outLog[i], expOut[t][i], $sformatf("outputPort update %0d", i));
		checkCount(word_t'(wrAddrLog.size()), word_t'(writeCount[t]), "data writes");
		for (i = 0; i < wrAddrLog.size() && i < writeCount[t]; i++) begin
			checkWord(wrAddrLog[i], expWrAddr[t][i], $sformatf("write %0d address", i));
			checkWord(wrDataLog[i], expWrData[t][i], $sformatf("write %0d data", i));
		end
	endtask

	initial begin
		int t;
		cycleLimit = 0;
		for (t = 0; t < NumTests; t++)
			cycleLimit += 20 + 2 * progLength[t];
		cycleCount = 0;
		while (cycleCount < cycleLimit) begin
			@(posedge clk);
			cycleCount++;
		end
		$display("Cycle limit of %0d reached, test %s never halted", cycleLimit, currentTest);
		$display("RESULT: FAIL");
		$finish;
	end

	initial begin
		int t;
		int passed;
		int failed;
		int errors;
		passed = 0;
		failed = 0;
		errors = 0;
		for (t = 0; t < NumTests; t++) begin
			currentTest = testName[t];
			testErrors = 0;
			applyReset(t);
			runProgram();
			compareResults(t);
			if (testErrors == 0) begin
				passed++;
				$display("test %0d %s: passed", t, testName[t]);
			end else begin
				failed++;
				$display("test %0d %s: %0d checks failed", t, testName[t], testErrors);
			end
			errors += testErrors;
		end
		$display("%0d tests, %0d passed, %0d failed, %0d failed checks",
			NumTests, passed, failed, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

// ==== pipelineCpu.f ====
+incdir+bench
src/tscPkg.sv
src/alu.sv
src/regFile.sv
src/instDecoder.sv
src/hazardUnit.sv
src/pipelineCpu.sv
bench/pipelineCpuTb.sv

// ==== Bender.yml ====
package:
  name: pipeline_cpu

sources:
  - src/tscPkg.sv
  - src/alu.sv
  - src/regFile.sv
  - src/instDecoder.sv
  - src/hazardUnit.sv
  - src/pipelineCpu.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/pipelineCpuTb.sv
